// ==== tb.f ====
+incdir+tests
logic/s3g_proto_pkg.sv
logic/s3g_regs_pkg.sv
logic/out_reg_bank.sv
logic/interrupt_unit.sv
logic/response_builder.sv
logic/command_fsm.sv
logic/s3g_executor_top.sv
tests/tb_s3g_executor.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_s3g_executor

./obj_dir/Vtb_s3g_executor > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log
then
    exit 1
fi
echo "Simulation finished without failures"

// ==== tests/tb_tasks.svh ====
// Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0])
        return (state >> 1) ^ 32'h8020_0003;
    return state >> 1;
endfunction

task take_bits(input int n, output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < n; i++)
    begin
        value      = {value[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
endtask

// Input word pattern with every byte tied to the index
function automatic word_t fill_word(input int idx);
    logic [7:0] a;
    a = 8'(idx);
    return {a ^ 8'h3C, ~a, a + 8'h71, a};
endfunction

function automatic tx_packet_t build_reply(input byte_t len, input logic [39:0] bytes);
    tx_packet_t pkt;
    int i;
    pkt.len = len;
    for (i = 0; i < 5; i++)
        pkt.payload[i] = bytes[8*i +: 8];
    return pkt;
endfunction

task check_value(input string name, input logic [47:0] expected, input logic [47:0] actual);
    assert (actual === expected)
    else
    begin
        $display("** Error at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
        stop_with_failure();
    end
endtask

task send_request(input byte_t len, input byte_t op, input logic [39:0] args);
    rx_packet_t pkt;
    pkt.len          = len;
    pkt.payload[0]   = op;
    pkt.payload[5:1] = args;  // Byte 1 in the low bits
    @(posedge clk);
    rx_packet_done <= 1'b1;
    rx_packet      <= pkt;
    @(posedge clk);
    rx_packet_done <= 1'b0;
    rx_packet      <= '0;
endtask

task send_error_pulse();
    @(posedge clk);
    rx_packet_error <= 1'b1;
    @(posedge clk);
    rx_packet_error <= 1'b0;
endtask

task pulse_int_lines(input int_vec_t lines);
    @(posedge clk);
    int_lines <= lines;
    @(posedge clk);
    int_lines <= '0;
endtask

task reply_after(input int cycles, input string what, input tx_packet_t expected);
    repeat (cycles) @(negedge clk);
    check_value("tx_packet_wr", 48'(1'b1), 48'(tx_packet_wr));
    check_value($sformatf("tx_packet (%s)", what), expected, tx_packet);
endtask

task await_reply(input int max_cycles, output int cycles);
    cycles = 0;
    do
    begin
        @(negedge clk);
        cycles++;
        assert (cycles <= max_cycles)
        else
        begin
            $display("No packet from the DUT within %0d cycles, time %0t", max_cycles, $time);
            stop_with_failure();
        end
    end
    while (tx_packet_wr !== 1'b1);
endtask

task no_reply_for(input int cycles);
    int i;
    for (i = 0; i < cycles; i++)
    begin
        @(negedge clk);
        check_value("tx_packet_wr", 48'(1'b0), 48'(tx_packet_wr));
        check_value("tx_packet", 48'(0), tx_packet);  // Zero between packets
    end
endtask

task compare_out_regs();
    int i;
    for (i = 0; i < num_regs; i++)
        check_value($sformatf("out_regs[%0d]", i), 48'(expected_regs[i]), 48'(out_regs[i]));
endtask

// FSM leaves busy one cycle after tx_busy falls
task wait_idle();
    repeat (2) @(negedge clk);
    while (tx_busy)
        @(negedge clk);
    repeat (2) @(negedge clk);
endtask

task basic_replies();
    send_request(8'd0, 8'd0, '0);
    reply_after(1, "ping", build_reply(8'd1, {32'd0, code_ok}));
    wait_idle();
    send_request(8'd1, op_version, '0);
    reply_after(1, "version", build_reply(8'd3, {16'd0, 8'hCE, 8'hBA, code_ok}));
    wait_idle();
    send_request(8'd1, 8'd27, '0);  // Extended version is no longer served
    reply_after(1, "unknown", build_reply(8'd1, {32'd0, code_unknown}));
    wait_idle();
    send_error_pulse();
    reply_after(1, "error", build_reply(8'd1, {32'd0, code_error}));
    wait_idle();
endtask

task out_reg_writes();
    logic [31:0] idx;
    logic [31:0] data;
    int n;
    for (n = 0; n < 3; n++)
    begin
        take_bits(6, idx);
        take_bits(32, data);
        expected_regs[idx[5:0]] = data;
        send_request(8'd6, op_write_out_reg, {data, idx[7:0]});
        reply_after(1, "write", build_reply(8'd1, {32'd0, code_ok}));
        compare_out_regs();
        wait_idle();
    end
endtask

task in_reg_reads();
    logic [31:0] idx;
    int n;
    for (n = 0; n < 2; n++)
    begin
        take_bits(6, idx);
        send_request(8'd2, op_read_in_reg, {32'd0, idx[7:0]});
        reply_after(3, "read", build_reply(8'd5, {fill_word(int'(idx)), code_ok}));
        wait_idle();
    end
endtask

task strobes_and_masking();
    logic [31:0] value;
    logic [31:0] line;
    int_vec_t    bit_vec;
    take_bits(32, value);
    send_request(8'd5, op_out_stbs, {8'd0, value});
    reply_after(1, "strobe", build_reply(8'd1, {32'd0, code_ok}));
    check_value("out_stbs", 48'(value), 48'(out_stbs));
    @(negedge clk);
    check_value("out_stbs", 48'(0), 48'(out_stbs));  // Single cycle only
    wait_idle();

    take_bits(5, line);
    bit_vec = int_vec_t'(1) << line[4:0];
    send_request(8'd5, op_mask_ints, {8'd0, ~bit_vec});
    reply_after(1, "mask", build_reply(8'd1, {32'd0, code_ok}));
    wait_idle();
    pulse_int_lines(bit_vec);
    @(negedge clk);
    check_value("pending_ints", 48'(bit_vec), 48'(pending_ints));
    no_reply_for(100);

    send_request(8'd5, op_clear_ints, {8'd0, bit_vec});
    reply_after(1, "clear", build_reply(8'd1, {32'd0, code_ok}));
    check_value("pending_ints", 48'(0), 48'(pending_ints));
    wait_idle();
endtask

task interrupt_holdoff();
    logic [31:0] line;
    int_vec_t    bit_vec;
    int          gap;
    busy_auto = 1'b0;
    send_request(8'd5, op_mask_ints, {8'd0, 32'hFFFF_FFFF});
    reply_after(1, "unmask", build_reply(8'd1, {32'd0, code_ok}));
    wait_idle();

    take_bits(5, line);
    bit_vec = int_vec_t'(1) << line[4:0];
    pulse_int_lines(bit_vec);
    await_reply(10, gap);
    check_value("tx_packet (report)", build_reply(8'd5, {bit_vec, code_interrupt}), tx_packet);
    await_reply(100, gap);
    assert (gap >= holdoff)
    else
    begin
        $display("Interrupt report repeated after %0d cycles, inside the holdoff", gap);
        stop_with_failure();
    end
    check_value("tx_packet (report)", build_reply(8'd5, {bit_vec, code_interrupt}), tx_packet);
    wait_idle();

    send_request(8'd5, op_clear_ints, {8'd0, bit_vec});
    reply_after(1, "clear", build_reply(8'd1, {32'd0, code_ok}));
    no_reply_for(50);
    busy_auto = 1'b1;
endtask

task back_pressure();
    logic [31:0] idx;
    logic [31:0] data;
    busy_hold = 1'b1;
    send_request(8'd0, 8'd0, '0);
    reply_after(1, "ping", build_reply(8'd1, {32'd0, code_ok}));
    repeat (6) @(negedge clk);

    // Ignored while the transmitter is busy
    take_bits(6, idx);
    take_bits(32, data);
    send_request(8'd6, op_write_out_reg, {data, idx[7:0]});
    no_reply_for(12);
    compare_out_regs();
    busy_hold = 1'b0;
    wait_idle();

    take_bits(6, idx);
    take_bits(32, data);
    expected_regs[idx[5:0]] = data;
    send_request(8'd6, op_write_out_reg, {data, idx[7:0]});
    reply_after(1, "write", build_reply(8'd1, {32'd0, code_ok}));
    compare_out_regs();
    wait_idle();
endtask

// ==== tests/tb_s3g_executor.sv ====
module tb_s3g_executor;
    import s3g_proto_pkg::*;
    import s3g_regs_pkg::*;

    localparam int num_tests       = 6;
    localparam int watchdog_cycles = 60 * num_tests + 2000;
    localparam int holdoff         = 40;

    // Response codes as the host sees them
    localparam byte_t code_ok        = 8'h81;
    localparam byte_t code_error     = 8'h80;
    localparam byte_t code_unknown   = 8'h85;
    localparam byte_t code_interrupt = 8'h50;

    logic        clk = 1'b0;
    logic        rst;
    logic        rx_packet_done;
    logic        rx_packet_error;
    rx_packet_t  rx_packet;
    logic        tx_busy = 1'b0;
    logic        tx_packet_wr;
    tx_packet_t  tx_packet;
    word_array_t in_regs;
    word_array_t out_regs;
    int_vec_t    out_stbs;
    int_vec_t    int_lines;
    int_vec_t    pending_ints;

    word_array_t expected_regs;  // Model of the output registers
    logic [31:0] lfsr_state;
    logic [1:0]  busy_left = 2'd0;
    logic        busy_auto = 1'b1;  // Busy after every packet
    logic        busy_hold = 1'b0;

    s3g_executor_top #(
        .holdoff_cycles (32'(holdoff)),
        .fw_version     (16'hCEBA)
    ) i_dut (
        .clk             (clk),
        .rst             (rst),
        .rx_packet_done  (rx_packet_done),
        .rx_packet_error (rx_packet_error),
        .rx_packet       (rx_packet),
        .tx_busy         (tx_busy),
        .tx_packet_wr    (tx_packet_wr),
        .tx_packet       (tx_packet),
        .in_regs         (in_regs),
        .out_regs        (out_regs),
        .out_stbs        (out_stbs),
        .int_lines       (int_lines),
        .pending_ints    (pending_ints)
    );

    always #10 clk = ~clk;

    // Transmitter model, busy for 3 cycles per packet
    always @(posedge clk)
    begin
        if (rst)
        begin
            busy_left <= 2'd0;
            tx_busy   <= 1'b0;
        end
        else if (tx_packet_wr && busy_auto)
        begin
            busy_left <= 2'd2;
            tx_busy   <= 1'b1;
        end
        else if (busy_left != 2'd0)
        begin
            busy_left <= busy_left - 2'd1;
            tx_busy   <= 1'b1;
        end
        else
            tx_busy <= busy_hold;
    end

    task stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    `include "tb_tasks.svh"

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        stop_with_failure();
    end

    initial
    begin
        int i;
        lfsr_state      = 32'h56da42fd;
        expected_regs   = '0;
        rst             <= 1'b1;
        rx_packet_done  <= 1'b0;
        rx_packet_error <= 1'b0;
        rx_packet       <= '0;
        int_lines       <= '0;
        for (i = 0; i < num_regs; i++)
            in_regs[i] <= fill_word(i);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        basic_replies();
        out_reg_writes();
        in_reg_reads();
        strobes_and_masking();
        interrupt_holdoff();
        back_pressure();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== logic/s3g_executor_top.sv ====
module s3g_executor_top #(
    parameter logic [31:0] holdoff_cycles = 32'd1000000,
    parameter logic [15:0] fw_version     = 16'hCEBA
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       rx_packet_done,
    input  logic                       rx_packet_error,
    input  s3g_proto_pkg::rx_packet_t  rx_packet,

    input  logic                       tx_busy,
    output logic                       tx_packet_wr,
    output s3g_proto_pkg::tx_packet_t  tx_packet,

    input  s3g_regs_pkg::word_array_t  in_regs,
    output s3g_regs_pkg::word_array_t  out_regs,
    output s3g_regs_pkg::int_vec_t     out_stbs,
    input  s3g_regs_pkg::int_vec_t     int_lines,
    output s3g_regs_pkg::int_vec_t     pending_ints
);
    import s3g_proto_pkg::*;
    import s3g_regs_pkg::*;

    reg_write_t reg_write;
    int_vec_t   int_clear;
    logic       mask_wr;
    int_vec_t   mask_value;
    logic       timer_clear;
    logic       int_sent;
    logic       int_request;
    rsp_kind_t  rsp_kind;
    reg_idx_t   in_sel;

    command_fsm i_command_fsm (
        .clk             (clk),
        .rst             (rst),
        .rx_packet_done  (rx_packet_done),
        .rx_packet_error (rx_packet_error),
        .rx_packet       (rx_packet),
        .tx_busy         (tx_busy),
        .int_request     (int_request),
        .reg_write       (reg_write),
        .out_stbs        (out_stbs),
        .int_clear       (int_clear),
        .mask_wr         (mask_wr),
        .mask_value      (mask_value),
        .timer_clear     (timer_clear),
        .int_sent        (int_sent),
        .rsp_kind        (rsp_kind),
        .in_sel          (in_sel)
    );

    interrupt_unit #(
        .holdoff_cycles (holdoff_cycles)
    ) i_interrupt_unit (
        .clk         (clk),
        .rst         (rst),
        .int_lines   (int_lines),
        .int_clear   (int_clear),
        .mask_wr     (mask_wr),
        .mask_value  (mask_value),
        .timer_clear (timer_clear),
        .int_sent    (int_sent),
        .int_request (int_request),
        .pending     (pending_ints)
    );

    response_builder #(
        .fw_version (fw_version)
    ) i_response_builder (
        .clk          (clk),
        .rst          (rst),
        .rsp_kind     (rsp_kind),
        .in_sel       (in_sel),
        .in_regs      (in_regs),
        .pending      (pending_ints),
        .tx_packet_wr (tx_packet_wr),
        .tx_packet    (tx_packet)
    );

    out_reg_bank i_out_reg_bank (
        .clk       (clk),
        .rst       (rst),
        .reg_write (reg_write),
        .out_regs  (out_regs)
    );

endmodule

// ==== logic/command_fsm.sv ====
module command_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rx_packet_done,
    input  logic                       rx_packet_error,
    input  s3g_proto_pkg::rx_packet_t  rx_packet,
    input  logic                       tx_busy,
    input  logic                       int_request,
    output s3g_regs_pkg::reg_write_t   reg_write,
    output s3g_regs_pkg::int_vec_t     out_stbs,
    output s3g_regs_pkg::int_vec_t     int_clear,
    output logic                       mask_wr,
    output s3g_regs_pkg::int_vec_t     mask_value,
    output logic                       timer_clear,
    output logic                       int_sent,
    output s3g_proto_pkg::rsp_kind_t   rsp_kind,
    output s3g_regs_pkg::reg_idx_t     in_sel
);
    import s3g_proto_pkg::*;
    import s3g_regs_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_read_wait,
        st_delay,
        st_busy
    } state_t;

    state_t   state;
    state_t   next_state;
    byte_t    opcode;
    word_t    arg;      // Bytes 1..4, little endian
    word_t    wr_word;  // Bytes 2..5 for WRITE_OUT_REG
    int_vec_t next_stbs;
    reg_idx_t next_in_sel;

    assign opcode     = rx_packet.payload[0];
    assign arg        = {rx_packet.payload[4], rx_packet.payload[3],
                         rx_packet.payload[2], rx_packet.payload[1]};
    assign wr_word    = {rx_packet.payload[5], rx_packet.payload[4],
                         rx_packet.payload[3], rx_packet.payload[2]};
    assign mask_value = arg;

    always_comb
    begin
        next_state  = state;
        next_in_sel = in_sel;
        next_stbs   = '0;
        rsp_kind    = kind_none;
        reg_write   = '0;
        int_clear   = '0;
        mask_wr     = 1'b0;
        timer_clear = 1'b0;
        int_sent    = 1'b0;

        case (state)
            st_idle:
                if (rx_packet_done)
                begin
                    next_state = st_delay;
                    if (rx_packet.len == 8'd0)
                        rsp_kind = kind_ok;  // Ping
                    else
                    begin
                        case (opcode)
                            op_version:
                                rsp_kind = kind_version;
                            op_write_out_reg:
                            begin
                                reg_write.stb  = 1'b1;
                                reg_write.idx  = rx_packet.payload[1][5:0];
                                reg_write.data = wr_word;
                                rsp_kind       = kind_ok;
                            end
                            op_read_in_reg:
                            begin
                                next_in_sel = rx_packet.payload[1][5:0];
                                next_state  = st_read;  // Reply after the word settles
                            end
                            op_out_stbs:
                            begin
                                next_stbs = arg;
                                rsp_kind  = kind_ok;
                            end
                            op_clear_ints:
                            begin
                                int_clear   = arg;
                                timer_clear = 1'b1;
                                rsp_kind    = kind_ok;
                            end
                            op_mask_ints:
                            begin
                                mask_wr  = 1'b1;
                                rsp_kind = kind_ok;
                            end
                            default:
                                rsp_kind = kind_unknown;
                        endcase
                    end
                end
                else if (rx_packet_error)
                begin
                    rsp_kind   = kind_error;
                    next_state = st_delay;
                end
                else if (int_request)
                begin
                    rsp_kind   = kind_interrupt;
                    int_sent   = 1'b1;  // Reloads the holdoff timer
                    next_state = st_delay;
                end
            st_read:
                next_state = st_read_wait;
            st_read_wait:
            begin
                rsp_kind   = kind_read_reg;
                next_state = st_delay;
            end
            st_delay:
                next_state = st_busy;  // tx_busy not yet up
            st_busy:
                if (!tx_busy)
                    next_state = st_idle;
            default:
                next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= st_idle;
            in_sel   <= '0;
            out_stbs <= '0;
        end
        else
        begin
            state    <= next_state;
            in_sel   <= next_in_sel;
            out_stbs <= next_stbs;  // One-cycle pulse
        end
    end

endmodule

// ==== logic/response_builder.sv ====
module response_builder #(
    parameter logic [15:0] fw_version = 16'hCEBA
) (
    input  logic                       clk,
    input  logic                       rst,
    input  s3g_proto_pkg::rsp_kind_t   rsp_kind,
    input  s3g_regs_pkg::reg_idx_t     in_sel,
    input  s3g_regs_pkg::word_array_t  in_regs,
    input  s3g_regs_pkg::int_vec_t     pending,
    output logic                       tx_packet_wr,
    output s3g_proto_pkg::tx_packet_t  tx_packet
);
    import s3g_proto_pkg::*;
    import s3g_regs_pkg::*;

    word_t in_word;

    function automatic tx_packet_t code_reply(byte_t code);
        tx_packet_t pkt;
        pkt            = '0;
        pkt.len        = 8'd1;
        pkt.payload[0] = code;
        return pkt;
    endfunction

    // Code followed by a 32-bit word, low byte first
    function automatic tx_packet_t word_reply(byte_t code, word_t data);
        tx_packet_t pkt;
        pkt            = '0;
        pkt.len        = 8'd5;
        pkt.payload[0] = code;
        pkt.payload[1] = data[7:0];
        pkt.payload[2] = data[15:8];
        pkt.payload[3] = data[23:16];
        pkt.payload[4] = data[31:24];
        return pkt;
    endfunction

    always_ff @(posedge clk)
    begin
        in_word <= in_regs[in_sel];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tx_packet_wr <= 1'b0;
            tx_packet    <= '0;
        end
        else
        begin
            tx_packet_wr <= (rsp_kind != kind_none);
            case (rsp_kind)
                kind_ok:        tx_packet <= code_reply(rsp_ok);
                kind_error:     tx_packet <= code_reply(rsp_error);
                kind_unknown:   tx_packet <= code_reply(rsp_unknown);
                kind_version:
                begin
                    tx_packet            <= code_reply(rsp_ok);
                    tx_packet.len        <= 8'd3;
                    tx_packet.payload[1] <= fw_version[7:0];
                    tx_packet.payload[2] <= fw_version[15:8];
                end
                kind_read_reg:  tx_packet <= word_reply(rsp_ok, in_word);
                kind_interrupt: tx_packet <= word_reply(rsp_interrupt, pending);
                default:        tx_packet <= '0;  // Zero between packets
            endcase
        end
    end

endmodule

// ==== logic/interrupt_unit.sv ====
module interrupt_unit #(
    parameter logic [31:0] holdoff_cycles = 32'd1000000
) (
    input  logic                    clk,
    input  logic                    rst,
    input  s3g_regs_pkg::int_vec_t  int_lines,
    input  s3g_regs_pkg::int_vec_t  int_clear,
    input  logic                    mask_wr,
    input  s3g_regs_pkg::int_vec_t  mask_value,
    input  logic                    timer_clear,
    input  logic                    int_sent,
    output logic                    int_request,
    output s3g_regs_pkg::int_vec_t  pending
);

    logic [31:0] mask;
    logic [31:0] timer;

    // Ready to report only once the holdoff has run out
    assign int_request = ((pending & mask) != '0) && (timer == '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pending <= '0;
            mask    <= '1;
            timer   <= '0;
        end
        else
        begin
            pending <= (pending & ~int_clear) | int_lines;  // Sticky

            if (mask_wr)
                mask <= mask_value;

            if (timer_clear)
                timer <= '0;
            else if (int_sent)
                timer <= holdoff_cycles;
            else if (timer != '0)
                timer <= timer - 32'd1;
        end
    end

endmodule

// ==== logic/out_reg_bank.sv ====
module out_reg_bank (
    input  logic                       clk,
    input  logic                       rst,
    input  s3g_regs_pkg::reg_write_t   reg_write,
    output s3g_regs_pkg::word_array_t  out_regs
);

    // Single write port, one register per strobe
    always_ff @(posedge clk)
    begin
        if (rst)
            out_regs <= '0;
        else if (reg_write.stb)
            out_regs[reg_write.idx] <= reg_write.data;
    end

endmodule

// ==== logic/s3g_regs_pkg.sv ====
package s3g_regs_pkg;

    localparam int num_regs = 64;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  reg_idx_t;

    // One word per register, register 0 in the low bits
    typedef word_t [num_regs-1:0] word_array_t;

    typedef logic [31:0] int_vec_t;

    typedef struct packed {
        logic     stb;
        reg_idx_t idx;
        word_t    data;
    } reg_write_t;

endpackage

// ==== logic/s3g_proto_pkg.sv ====
package s3g_proto_pkg;

    typedef logic [7:0] byte_t;

    // Command numbers, payload byte 0 of a request
    localparam byte_t op_version       = 8'd0;
    localparam byte_t op_write_out_reg = 8'd60;
    localparam byte_t op_read_in_reg   = 8'd61;
    localparam byte_t op_out_stbs      = 8'd62;
    localparam byte_t op_clear_ints    = 8'd63;
    localparam byte_t op_mask_ints     = 8'd64;

    // First payload byte of a response
    localparam byte_t rsp_ok        = 8'h81;
    localparam byte_t rsp_error     = 8'h80;
    localparam byte_t rsp_unknown   = 8'h85;
    localparam byte_t rsp_interrupt = 8'h50;

    typedef enum logic [2:0] {
        kind_none,
        kind_ok,
        kind_error,
        kind_unknown,
        kind_version,
        kind_read_reg,
        kind_interrupt
    } rsp_kind_t;

    // payload[0] holds the opcode
    typedef struct packed {
        byte_t        len;
        byte_t [5:0]  payload;
    } rx_packet_t;

    typedef struct packed {
        byte_t        len;
        byte_t [4:0]  payload;  // Code, then data low byte first
    } tx_packet_t;

endpackage
